/* src/cps_cfg.svh */
// CPS memory map configuration: SDRAM widths and ROM download region boundaries
`ifndef CPS_CFG_SVH
`define CPS_CFG_SVH

// SDRAM bank word address width
`define CPS_SDRAM_AW 22

// Main CPU work RAM, in 16-bit words
`define CPS_RAM_AW 17

// Download stream layout, byte addresses on ioctl_addr
// Main ROM sits from zero up to the sound ROM
`define CPS_SND_START 25'h040_0000

// Graphics ROM fills everything from here upwards
`define CPS_GFX_START 25'h048_0000

`endif

/* src/cps_pkg.sv */
// CPS memory types: bank 0 sequencer states, slot owners and programming banks
package cps_pkg;

`include "cps_cfg.svh"

    // Word address on an SDRAM bank
    typedef logic [`CPS_SDRAM_AW-1:0] sdram_addr_t;

    // Bank 0 access sequencer
    typedef enum logic [1:0] {
        ARB_IDLE     = 2'd0,
        ARB_WAIT_ACK = 2'd1,
        ARB_WAIT_RDY = 2'd2
    } arb_state_e;

    // Requester currently holding bank 0
    typedef enum logic {
        OWN_MAIN = 1'b0,
        OWN_DMA  = 1'b1
    } slot_owner_e;

    // SDRAM bank used while programming the ROMs
    typedef enum logic [1:0] {
        BANK_MAIN_ROM = 2'd0,
        BANK_SND_ROM  = 2'd1,
        BANK_GFX_ROM  = 2'd2
    } prog_bank_e;

endpackage

/* src/mem_slot_if.sv */
// Memory slot channel: one cs/ok requester on a shared SDRAM bank
`timescale 1ns/1ps

`include "cps_cfg.svh"

interface mem_slot_if;

    logic [`CPS_SDRAM_AW-1:0] addr;
    logic [15:0]              din;
    // Active low byte write mask
    logic [1:0]               din_m;
    logic                     rnw;
    logic                     cs;
    // One cycle pulse, dout valid with it on reads
    logic                     ok;
    logic [15:0]              dout;

    modport requester (
        output addr, din, din_m, rnw, cs,
        input  ok, dout
    );

    modport arbiter (
        input  addr, din, din_m, rnw, cs,
        output ok, dout
    );

endinterface

/* src/cen_gen.sv */
// CPU clock enable generator: 16 MHz and 8 MHz pulses from the 48 MHz clock
`timescale 1ns/1ps

module cen_gen (
    input  logic clk,
    input  logic arst_n,
    output logic cen16,
    output logic cen8
);

    logic [1:0] div_cnt;
    logic       half;
    logic       wrap;

    // Divide by three
    assign wrap = (div_cnt == 2'd2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= 2'd0;
            half    <= 1'b0;
            cen16   <= 1'b0;
            cen8    <= 1'b0;
        end else begin
            div_cnt <= wrap ? 2'd0 : div_cnt + 2'd1;
            cen16   <= wrap;
            // Every other 16 MHz pulse, starting with the first
            cen8    <= wrap & ~half;
            if (wrap) begin
                half <= ~half;
            end
        end
    end

endmodule

/* src/rom_loader.sv */
// ROM loader: turns the download byte stream into masked 16-bit SDRAM program words
`timescale 1ns/1ps

`include "cps_cfg.svh"

module rom_loader (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     downloading,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    input  logic                     prog_rdy,
    output logic [`CPS_SDRAM_AW-1:0] prog_addr,
    output logic [15:0]              prog_data,
    output logic [1:0]               prog_mask,
    output cps_pkg::prog_bank_e      prog_ba,
    output logic                     prog_we,
    output logic                     dwnld_busy
);

    logic                ioctl_wr_l;
    logic                wr_edge;
    logic                start;
    logic [24:0]         region_base;
    logic [24:0]         byte_off;
    cps_pkg::prog_bank_e region_bank;

    assign wr_edge = ioctl_wr & ~ioctl_wr_l;
    // New writes are dropped while a word is still pending
    assign start   = wr_edge & downloading & ~prog_we;

    // Region decode on the byte address
    always_comb begin
        if (ioctl_addr < `CPS_SND_START) begin
            region_base = 25'd0;
            region_bank = cps_pkg::BANK_MAIN_ROM;
        end else if (ioctl_addr < `CPS_GFX_START) begin
            region_base = `CPS_SND_START;
            region_bank = cps_pkg::BANK_SND_ROM;
        end else begin
            region_base = `CPS_GFX_START;
            region_bank = cps_pkg::BANK_GFX_ROM;
        end
    end

    assign byte_off = ioctl_addr - region_base;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ioctl_wr_l <= 1'b0;
            prog_we    <= 1'b0;
        end else begin
            ioctl_wr_l <= ioctl_wr;
            if (prog_we) begin
                // Held until the SDRAM has taken the word
                if (prog_rdy) begin
                    prog_we <= 1'b0;
                end
            end else if (start) begin
                prog_we <= 1'b1;
            end
        end
    end

    // Word payload, captured with the write strobe
    always_ff @(posedge clk) begin
        if (start) begin
            prog_addr <= byte_off[`CPS_SDRAM_AW:1];
            prog_data <= {ioctl_data, ioctl_data};
            // Active low: even byte goes low, odd byte goes high
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog_ba   <= region_bank;
        end
    end

    assign dwnld_busy = downloading | prog_we;

endmodule

/* src/bank0_arbiter.sv */
// Bank 0 arbiter: round-robin sharing of SDRAM bank 0 between main RAM and VRAM DMA
`timescale 1ns/1ps

`include "cps_cfg.svh"

module bank0_arbiter (
    input  logic                     clk,
    input  logic                     arst_n,
    mem_slot_if.arbiter              main_slot,
    mem_slot_if.arbiter              dma_slot,
    output logic [`CPS_SDRAM_AW-1:0] ba0_addr,
    output logic                     ba0_rd,
    output logic                     ba0_wr,
    output logic [15:0]              ba0_din,
    output logic [1:0]               ba0_din_m,
    input  logic                     ba0_ack,
    input  logic                     ba0_rdy,
    input  logic [31:0]              data_read
);

    cps_pkg::arb_state_e  state;
    cps_pkg::slot_owner_e owner;
    cps_pkg::sdram_addr_t lat_addr;
    logic [15:0]          lat_din;
    logic [1:0]           lat_din_m;
    logic                 lat_rnw;
    logic [15:0]          rd_data;
    logic                 main_ok;
    logic                 dma_ok;
    logic                 req_main;
    logic                 req_dma;
    logic                 pick_dma;
    logic                 start;
    logic                 finish;

    // A slot is still holding cs during its ok cycle, that is not a new request
    assign req_main = main_slot.cs & ~main_ok;
    assign req_dma  = dma_slot.cs & ~dma_ok;

    // Round robin on a tie, owner holds the previous winner
    assign pick_dma = req_dma & (~req_main | (owner == cps_pkg::OWN_MAIN));
    assign start    = (state == cps_pkg::ARB_IDLE) & (req_main | req_dma);
    assign finish   = (state == cps_pkg::ARB_WAIT_RDY) & ba0_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= cps_pkg::ARB_IDLE;
            // Main RAM wins the first tie
            owner   <= cps_pkg::OWN_DMA;
            ba0_rd  <= 1'b0;
            ba0_wr  <= 1'b0;
            main_ok <= 1'b0;
            dma_ok  <= 1'b0;
        end else begin
            main_ok <= finish & (owner == cps_pkg::OWN_MAIN);
            dma_ok  <= finish & (owner == cps_pkg::OWN_DMA);
            case (state)
                cps_pkg::ARB_IDLE: begin
                    if (start) begin
                        owner  <= pick_dma ? cps_pkg::OWN_DMA : cps_pkg::OWN_MAIN;
                        ba0_rd <= pick_dma ? dma_slot.rnw : main_slot.rnw;
                        ba0_wr <= pick_dma ? ~dma_slot.rnw : ~main_slot.rnw;
                        state  <= cps_pkg::ARB_WAIT_ACK;
                    end
                end
                cps_pkg::ARB_WAIT_ACK: begin
                    // Strobe stays up until the controller accepts it
                    if (ba0_ack) begin
                        ba0_rd <= 1'b0;
                        ba0_wr <= 1'b0;
                        state  <= cps_pkg::ARB_WAIT_RDY;
                    end
                end
                cps_pkg::ARB_WAIT_RDY: begin
                    if (ba0_rdy) begin
                        state <= cps_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state  <= cps_pkg::ARB_IDLE;
                    ba0_rd <= 1'b0;
                    ba0_wr <= 1'b0;
                end
            endcase
        end
    end

    // Granted request is frozen for the whole SDRAM cycle
    always_ff @(posedge clk) begin
        if (start) begin
            if (pick_dma) begin
                lat_addr  <= dma_slot.addr;
                lat_din   <= dma_slot.din;
                lat_din_m <= dma_slot.din_m;
                lat_rnw   <= dma_slot.rnw;
            end else begin
                lat_addr  <= main_slot.addr;
                lat_din   <= main_slot.din;
                lat_din_m <= main_slot.din_m;
                lat_rnw   <= main_slot.rnw;
            end
        end
        // Bank 0 data arrives on the low half of the read bus
        if (finish && lat_rnw) begin
            rd_data <= data_read[15:0];
        end
    end

    assign ba0_addr  = lat_addr;
    assign ba0_din   = lat_din;
    assign ba0_din_m = lat_din_m;

    assign main_slot.ok   = main_ok;
    assign main_slot.dout = rd_data;
    assign dma_slot.ok    = dma_ok;
    assign dma_slot.dout  = rd_data;

endmodule

/* src/game_mem_top.sv */
// Game memory top: CPU clock enables, ROM download path and SDRAM bank 0 sharing
`timescale 1ns/1ps

`include "cps_cfg.svh"

module game_mem_top (
    input  logic                     clk,
    input  logic                     arst_n,
    // CPU clock enables
    output logic                     cpu_cen16,
    output logic                     cpu_cen8,
    // ROM download
    input  logic                     downloading,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    output logic                     dwnld_busy,
    // SDRAM programming port
    output logic [`CPS_SDRAM_AW-1:0] prog_addr,
    output logic [15:0]              prog_data,
    output logic [1:0]               prog_mask,
    output logic [1:0]               prog_ba,
    output logic                     prog_we,
    input  logic                     prog_rdy,
    // Main CPU work RAM
    input  logic [`CPS_RAM_AW-1:0]   main_ram_addr,
    input  logic [15:0]              main_ram_din,
    input  logic [1:0]               main_ram_dsn,
    input  logic                     main_ram_rnw,
    input  logic                     main_ram_cs,
    output logic                     main_ram_ok,
    output logic [15:0]              main_ram_data,
    // Video RAM DMA, read only
    input  logic [`CPS_RAM_AW-1:0]   vram_dma_addr,
    input  logic                     vram_dma_cs,
    output logic                     vram_dma_ok,
    output logic [15:0]              vram_dma_data,
    // Bank 0, read/write
    output logic [`CPS_SDRAM_AW-1:0] ba0_addr,
    output logic                     ba0_rd,
    output logic                     ba0_wr,
    output logic [15:0]              ba0_din,
    output logic [1:0]               ba0_din_m,
    input  logic                     ba0_ack,
    input  logic                     ba0_rdy,
    input  logic [31:0]              data_read
);

    mem_slot_if main_slot ();
    mem_slot_if dma_slot ();

    cen_gen u_cen (
        .clk    ( clk       ),
        .arst_n ( arst_n    ),
        .cen16  ( cpu_cen16 ),
        .cen8   ( cpu_cen8  )
    );

    rom_loader u_loader (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_rdy    ( prog_rdy    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_ba     ( prog_ba     ),
        .prog_we     ( prog_we     ),
        .dwnld_busy  ( dwnld_busy  )
    );

    // Work RAM at the bottom of bank 0
    assign main_slot.addr  = {{(`CPS_SDRAM_AW-`CPS_RAM_AW){1'b0}}, main_ram_addr};
    assign main_slot.din   = main_ram_din;
    assign main_slot.din_m = main_ram_dsn;
    assign main_slot.rnw   = main_ram_rnw;
    assign main_slot.cs    = main_ram_cs;
    assign main_ram_ok     = main_slot.ok;
    assign main_ram_data   = main_slot.dout;

    // VRAM copy lives in the upper half of bank 0
    assign dma_slot.addr  = {1'b1, {(`CPS_SDRAM_AW-`CPS_RAM_AW-1){1'b0}}, vram_dma_addr};
    assign dma_slot.din   = 16'd0;
    assign dma_slot.din_m = 2'b11;
    assign dma_slot.rnw   = 1'b1;
    assign dma_slot.cs    = vram_dma_cs;
    assign vram_dma_ok    = dma_slot.ok;
    assign vram_dma_data  = dma_slot.dout;

    bank0_arbiter u_arb (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .main_slot ( main_slot ),
        .dma_slot  ( dma_slot  ),
        .ba0_addr  ( ba0_addr  ),
        .ba0_rd    ( ba0_rd    ),
        .ba0_wr    ( ba0_wr    ),
        .ba0_din   ( ba0_din   ),
        .ba0_din_m ( ba0_din_m ),
        .ba0_ack   ( ba0_ack   ),
        .ba0_rdy   ( ba0_rdy   ),
        .data_read ( data_read )
    );

endmodule

/* bench/sdram_bank_model.sv */
// SDRAM model: bank 0 read/write port and programming port with random ack and rdy delays
`timescale 1ns/1ps

`include "cps_cfg.svh"

module sdram_bank_model #(
    parameter logic [31:0] SEED = 32'd75
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`CPS_SDRAM_AW-1:0] ba0_addr,
    input  logic                     ba0_rd,
    input  logic                     ba0_wr,
    input  logic [15:0]              ba0_din,
    input  logic [1:0]               ba0_din_m,
    output logic                     ba0_ack,
    output logic                     ba0_rdy,
    output logic [31:0]              data_read,
    input  logic                     prog_we,
    output logic                     prog_rdy
);

    logic [31:0] seed = SEED;
    logic [15:0] mem [int unsigned];

    // Delay of 1 to 4 cycles
    function automatic int unsigned delay();
        seed = seed * 32'd1103515245 + 32'd12345;
        return int'(seed[17:16]) + 1;
    endfunction

    // Unwritten words read back as a pattern of their whole address
    function automatic logic [15:0] word_at(input logic [`CPS_SDRAM_AW-1:0] a);
        if (mem.exists(int'(a))) begin
            return mem[int'(a)];
        end
        return a[15:0] ^ {a[21:16], a[21:12]};
    endfunction

    task automatic serve_bank();
        logic [15:0] w;
        repeat (delay() - 1) @(posedge clk);
        #1 ba0_ack = 1'b1;
        if (ba0_wr) begin
            w = word_at(ba0_addr);
            // Active low byte enables
            if (!ba0_din_m[0]) w[7:0] = ba0_din[7:0];
            if (!ba0_din_m[1]) w[15:8] = ba0_din[15:8];
            mem[int'(ba0_addr)] = w;
        end
        @(posedge clk);
        #2 ba0_ack = 1'b0;
        repeat (delay() - 1) @(posedge clk);
        w = word_at(ba0_addr);
        // Upper half carries junk, bank 0 data is the low half
        data_read = {~w, w};
        ba0_rdy = 1'b1;
        @(posedge clk);
        #2 ba0_rdy = 1'b0;
    endtask

    initial begin
        ba0_ack   = 1'b0;
        ba0_rdy   = 1'b0;
        data_read = 32'd0;
        forever begin
            @(posedge clk);
            #1;
            if (arst_n && (ba0_rd || ba0_wr)) serve_bank();
        end
    end

    initial begin
        prog_rdy = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (arst_n && prog_we) begin
                repeat (delay() - 1) @(posedge clk);
                #1 prog_rdy = 1'b1;
                @(posedge clk);
                #2 prog_rdy = 1'b0;
            end
        end
    end

endmodule

/* bench/tb_game_mem.sv */
// Testbench for the game memory top: clock enables, ROM download and bank 0 sharing
`timescale 1ns/1ps

`include "cps_cfg.svh"

module tb_game_mem;

    // Operation counts per test, the watchdog budget follows from them
    localparam int N_CEN  = 60;
    localparam int N_DL   = 40;
    localparam int N_MAIN = 50;
    localparam int N_DMA  = 20;
    localparam int N_TIE  = 10;
    localparam int N_OPS  = N_CEN + N_DL + 2 * N_MAIN + N_DMA + 3 * N_TIE;

    logic clk = 1'b0;
    logic arst_n, cpu_cen16, cpu_cen8, downloading, ioctl_wr, dwnld_busy;
    logic [24:0] ioctl_addr;
    logic [7:0] ioctl_data;
    logic [`CPS_SDRAM_AW-1:0] prog_addr, ba0_addr;
    logic [15:0] prog_data, main_ram_din, main_ram_data, vram_dma_data, ba0_din;
    logic [1:0] prog_mask, prog_ba, main_ram_dsn, ba0_din_m;
    logic prog_we, prog_rdy, main_ram_rnw, main_ram_cs, main_ram_ok;
    logic [`CPS_RAM_AW-1:0] main_ram_addr, vram_dma_addr;
    logic vram_dma_cs, vram_dma_ok, ba0_rd, ba0_wr, ba0_ack, ba0_rdy;
    logic [31:0] data_read;

    logic [31:0] seed = 32'd75;
    int errs = 0;
    int tests = 0;
    int bad_tests = 0;
    cps_pkg::slot_owner_e rr_last = cps_pkg::OWN_DMA;
    logic [15:0] ref_mem [int unsigned];

    game_mem_top dut (.*);
    sdram_bank_model #(.SEED(32'd75)) u_sdram (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    function automatic logic [15:0] ref_read(input logic [`CPS_SDRAM_AW-1:0] a);
        if (ref_mem.exists(int'(a))) return ref_mem[int'(a)];
        return a[15:0] ^ {a[21:16], a[21:12]};
    endfunction

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_addr(input string name, input logic [`CPS_SDRAM_AW-1:0] exp,
                              input logic [`CPS_SDRAM_AW-1:0] act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_bank(input string name, input cps_pkg::prog_bank_e exp,
                              input cps_pkg::prog_bank_e act);
        if (exp !== act) begin
            $display("error %s expected %s actual %s", name, exp.name(), act.name());
            errs++;
        end
    endtask

    task automatic check_owner(input string name, input cps_pkg::slot_owner_e exp,
                               input cps_pkg::slot_owner_e act);
        if (exp !== act) begin
            $display("error %s expected %s actual %s", name, exp.name(), act.name());
            errs++;
        end
    endtask

    task automatic report(input string name, input int n);
        tests++;
        if (n != 0) bad_tests++;
        $display("%s: %0d errors", name, n);
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic main_access(input logic rnw, input logic [16:0] a, input logic [15:0] d,
                               input logic [1:0] m, output logic [15:0] q);
        step();
        main_ram_rnw = rnw;
        main_ram_addr = a;
        main_ram_din = d;
        main_ram_dsn = m;
        main_ram_cs = 1'b1;
        do @(negedge clk); while (!main_ram_ok);
        q = main_ram_data;
        rr_last = cps_pkg::OWN_MAIN;
        step();
        main_ram_cs = 1'b0;
    endtask

    task automatic dma_read(input logic [16:0] a, output logic [15:0] q);
        step();
        vram_dma_addr = a;
        vram_dma_cs = 1'b1;
        do @(negedge clk); while (!vram_dma_ok);
        q = vram_dma_data;
        rr_last = cps_pkg::OWN_DMA;
        step();
        vram_dma_cs = 1'b0;
    endtask

    // Watchdog sized from the operation count
    initial begin
        #(N_OPS * 200 * 40);
        $display("timeout, the DUT stopped answering");
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [24:0] a, base;
        logic [`CPS_SDRAM_AW-1:0] woff;
        logic [16:0] addrs [N_MAIN];
        logic [16:0] ma, da;
        logic [15:0] q, w;
        cps_pkg::prog_bank_e bank;
        cps_pkg::slot_owner_e first, exp_owner;
        int e0, rs_errs, c16, c8, last16;
        logic md, dd, got_first;

        arst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        main_ram_addr = '0;
        main_ram_din = '0;
        main_ram_dsn = 2'b11;
        main_ram_rnw = 1'b1;
        main_ram_cs = 1'b0;
        vram_dma_addr = '0;
        vram_dma_cs = 1'b0;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;

        // Enables and idle outputs over the first 60 cycles
        e0 = errs;
        rs_errs = 0;
        c16 = 0;
        c8 = 0;
        last16 = 0;
        // Cycle k is sampled half a period after edge k out of reset
        @(negedge clk);
        for (int k = 1; k <= N_CEN; k++) begin
            @(negedge clk);
            if (ba0_rd || ba0_wr || prog_we || main_ram_ok || vram_dma_ok) begin
                $display("reset state: a strobe or ok output went high in cycle %0d", k);
                rs_errs++;
            end
            if (cpu_cen16) begin
                if (c16 > 0 && k - last16 != 3) begin
                    $display("clock enables: cen16 came %0d cycles after the last", k - last16);
                    errs++;
                end
                last16 = k;
                c16++;
            end
            if (cpu_cen8) begin
                c8++;
                if (!cpu_cen16) begin
                    $display("clock enables: cen8 came without cen16 in cycle %0d", k);
                    errs++;
                end
            end
        end
        check_word("cen16 count", 16'd20, 16'(c16));
        check_word("cen8 count", 16'd10, 16'(c8));
        report("clock enables", errs - e0);
        errs += rs_errs;
        report("reset state", rs_errs);

        e0 = errs;
        for (int i = 0; i < N_DL; i++) begin
            r = rnd();
            w = 16'(rnd());
            case (r % 3)
                0: begin
                    base = 25'd0;
                    woff = {6'd0, w};
                    bank = cps_pkg::BANK_MAIN_ROM;
                end
                1: begin
                    base = `CPS_SND_START;
                    woff = {4'd0, r[2:0], w[14:0]};
                    bank = cps_pkg::BANK_SND_ROM;
                end
                default: begin
                    base = `CPS_GFX_START;
                    woff = {2'd0, r[4:1], w};
                    bank = cps_pkg::BANK_GFX_ROM;
                end
            endcase
            // Byte address is the region base plus twice the word offset
            a = base + {2'd0, woff, r[0]};
            step();
            downloading = 1'b1;
            ioctl_addr = a;
            ioctl_data = r[15:8];
            ioctl_wr = 1'b1;
            step();
            ioctl_wr = 1'b0;
            // Busy now has to come from the pending word alone
            downloading = 1'b0;
            @(negedge clk);
            if (!prog_we) begin
                $display("download %0d: prog_we did not rise one cycle after ioctl_wr", i);
                errs++;
            end
            check_addr($sformatf("download %0d addr", i), woff, prog_addr);
            check_word($sformatf("download %0d data", i), {r[15:8], r[15:8]}, prog_data);
            check_word($sformatf("download %0d mask", i), a[0] ? 16'd1 : 16'd2,
                       {14'd0, prog_mask});
            check_bank($sformatf("download %0d bank", i), bank, cps_pkg::prog_bank_e'(prog_ba));
            if (!dwnld_busy) begin
                $display("download %0d: dwnld_busy low while a word is pending", i);
                errs++;
            end
            while (prog_we) @(negedge clk);
            if (dwnld_busy) begin
                $display("download %0d: dwnld_busy still high after the word was written", i);
                errs++;
            end
        end
        report("download words", errs - e0);

        e0 = errs;
        for (int i = 0; i < N_MAIN; i++) begin
            r = rnd();
            addrs[i] = {1'b0, r[31:16]};
            w = ref_read({5'd0, addrs[i]});
            if (!r[0]) w[7:0] = r[15:8];
            if (!r[1]) w[15:8] = r[11:4];
            ref_mem[int'({5'd0, addrs[i]})] = w;
            main_access(1'b0, addrs[i], {r[11:4], r[15:8]}, r[1:0], q);
        end
        for (int i = 0; i < N_MAIN; i++) begin
            main_access(1'b1, addrs[i], 16'd0, 2'b11, q);
            check_word($sformatf("main read %0d", i), ref_read({5'd0, addrs[i]}), q);
        end
        report("main ram write and readback", errs - e0);

        e0 = errs;
        for (int i = 0; i < N_DMA; i++) begin
            r = rnd();
            dma_read(r[16:0], q);
            check_word($sformatf("dma read %0d", i), ref_read({1'b1, 4'd0, r[16:0]}), q);
        end
        report("dma reads", errs - e0);

        e0 = errs;
        for (int i = 0; i < N_TIE; i++) begin
            // A lone access first sets up the round-robin history
            r = rnd();
            if (i % 2 == 0) dma_read(r[16:0], q);
            else main_access(1'b1, r[16:0], 16'd0, 2'b11, q);
            exp_owner = (rr_last == cps_pkg::OWN_MAIN) ? cps_pkg::OWN_DMA : cps_pkg::OWN_MAIN;
            r = rnd();
            ma = r[16:0];
            da = {r[0], r[31:16]};
            step();
            main_ram_rnw = 1'b1;
            main_ram_addr = ma;
            main_ram_cs = 1'b1;
            vram_dma_addr = da;
            vram_dma_cs = 1'b1;
            md = 1'b0;
            dd = 1'b0;
            got_first = 1'b0;
            first = cps_pkg::OWN_MAIN;
            while (!(md && dd)) begin
                @(negedge clk);
                if (main_ram_ok) begin
                    check_word($sformatf("tie %0d main", i), ref_read({5'd0, ma}),
                               main_ram_data);
                    md = 1'b1;
                    rr_last = cps_pkg::OWN_MAIN;
                    if (!got_first) first = cps_pkg::OWN_MAIN;
                    got_first = 1'b1;
                end
                if (vram_dma_ok) begin
                    check_word($sformatf("tie %0d dma", i), ref_read({1'b1, 4'd0, da}),
                               vram_dma_data);
                    dd = 1'b1;
                    rr_last = cps_pkg::OWN_DMA;
                    if (!got_first) first = cps_pkg::OWN_DMA;
                    got_first = 1'b1;
                end
                step();
                if (md) main_ram_cs = 1'b0;
                if (dd) vram_dma_cs = 1'b0;
            end
            check_owner($sformatf("tie %0d first owner", i), exp_owner, first);
        end
        report("simultaneous requests", errs - e0);

        $display("tests run %0d, tests with errors %0d, failed checks %0d", tests, bad_tests, errs);
        if (errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/cps_pkg.sv
src/mem_slot_if.sv
src/cen_gen.sv
src/rom_loader.sv
src/bank0_arbiter.sv
src/game_mem_top.sv
bench/sdram_bank_model.sv
bench/tb_game_mem.sv

/* run.sh */
#!/bin/bash
# Build the testbench with Verilator and run it; exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_game_mem -f sources.f -o sim_game_mem \
    && ./obj_dir/sim_game_mem | tee /dev/stderr | grep -qx "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
